//--- flist.f
+incdir+logic
logic/tile_pkg.sv
logic/tile_reg_bank.sv
logic/tile_reg_decoder.sv
logic/tile_addr_gen.sv
logic/tile_layer_top.sv
sim/tile_layer_sva.sv
sim/tile_layer_tb.sv

//--- logic/tile_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turns a decoded lookup into a tile map address and in-tile position
// Scrolled coordinates and map_addr wrap at 16 bits
// A miss reports zero address and position
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

module tile_addr_gen
  import tile_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         dec_valid,
  input  tile_lookup_t dec_pix,
  input  tile_cfg_t    cfg,
  output logic         res_valid,
  output tile_result_t res
);

  tile_word_t                  scr_x;
  tile_word_t                  scr_y;
  tile_word_t                  col_full;
  tile_word_t                  row_full;
  logic                        col_ok;
  logic                        row_ok;
  logic                        hit;
  logic [`TILE_PX_WIDTH:0]     tile_w;
  logic [`TILE_PX_WIDTH:0]     tile_h;
  tile_px_t                    mask_x;
  tile_px_t                    mask_y;
  tile_px_t                    in_x;
  tile_px_t                    in_y;
  logic [2*`TILE_MAP_LOG2-1:0] map_idx;
  tile_result_t                res_next;

  assign scr_x = cfg.ctrl0.flags.scroll ? tile_word_t'(dec_pix.x) + cfg.offset_x
                                        : tile_word_t'(dec_pix.x);
  assign scr_y = cfg.ctrl0.flags.scroll ? tile_word_t'(dec_pix.y) + cfg.offset_y
                                        : tile_word_t'(dec_pix.y);

  // Tile sides are powers of two, so division and modulo become shift and mask
  assign tile_w = 7'd8 << cfg.hsize;
  assign tile_h = 7'd8 << cfg.vsize;
  assign mask_x = tile_px_t'(tile_w - 7'd1);
  assign mask_y = tile_px_t'(tile_h - 7'd1);

  assign col_full = scr_x >> (3 + cfg.hsize);
  assign row_full = scr_y >> (3 + cfg.vsize);

  // Past the map edge is only legal when that axis wraps
  assign col_ok = cfg.ctrl0.flags.wrap_x || (col_full[`REG_DATA_WIDTH-1:`TILE_MAP_LOG2] == '0);
  assign row_ok = cfg.ctrl0.flags.wrap_y || (row_full[`REG_DATA_WIDTH-1:`TILE_MAP_LOG2] == '0);
  assign hit    = cfg.ctrl0.flags.enabled && col_ok && row_ok;

  // Row times map width plus column, with the low bits giving the modulo 32
  assign map_idx = {row_full[`TILE_MAP_LOG2-1:0], col_full[`TILE_MAP_LOG2-1:0]};

  assign in_x = scr_x[`TILE_PX_WIDTH-1:0] & mask_x;
  assign in_y = scr_y[`TILE_PX_WIDTH-1:0] & mask_y;

  always_comb begin
    res_next       = '0;
    res_next.layer = dec_pix.layer;
    res_next.hit   = hit;
    if (hit) begin
      res_next.map_addr = cfg.data_offset + tile_word_t'(map_idx);
      // Width minus one minus the position equals the mask minus it
      res_next.px_x     = cfg.ctrl0.flags.flip ? (mask_x - in_x) : in_x;
      res_next.px_y     = in_y;
    end
    // Fields the blend stage will need later
    res_next.en_8bit   = cfg.ctrl0.flags.en_8bit;
    res_next.nop       = cfg.ctrl0.flags.nop;
    res_next.transp    = cfg.ctrl0.flags.transp;
    res_next.alpha     = cfg.ctrl0.flags.alpha;
    res_next.color     = cfg.ctrl0.flags.color;
    res_next.nop_value = cfg.nop_value;
    res_next.color_key = cfg.color_key;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      res <= res_next;
    end
  end

endmodule

//--- logic/tile_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes, register indices and bit positions of the tile layers
// Register index 7 is reserved and always reads zero
// Pixel positions assume tiles of at most 64 pixels per side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

`define NUM_TILE_LAYERS      4
`define NUM_TILE_REGISTERS   8
`define REG_DATA_WIDTH       16

`define TILE_CTRL0           0
`define TILE_CTRL1           1
`define TILE_DATA_OFFSET     2
`define TILE_NOP_VALUE       3
`define TILE_COLOR_KEY       4
`define TILE_OFFSET_X        5
`define TILE_OFFSET_Y        6

// CTRL0 flag positions
`define TILE_LAYER_ENABLED   0
`define TILE_ENABLE_8_BIT    1
`define TILE_ENABLE_NOP      2
`define TILE_ENABLE_SCROLL   3
`define TILE_ENABLE_TRANSP   4
`define TILE_ENABLE_ALPHA    5
`define TILE_ENABLE_COLOR    6
`define TILE_ENABLE_WRAP_X   7
`define TILE_ENABLE_WRAP_Y   8
`define TILE_ENABLE_FLIP     9

// CTRL1 tile size fields
`define TILE_HSIZE_0         0
`define TILE_HSIZE_1         1
`define TILE_VSIZE_0         4
`define TILE_VSIZE_1         5

`define TILE_MAP_LOG2        5
`define SCREEN_COORD_WIDTH   10
`define TILE_PX_WIDTH        6

`endif

//--- logic/tile_layer_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile layer setup path top level
// Results arrive exactly two cycles after each pix_valid
// The consumer must take every result since nothing stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

module tile_layer_top
  import tile_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  input  tile_reg_addr_t             reg_addr,
  input  logic [`REG_DATA_WIDTH-1:0] reg_wdata,
  input  logic                       pix_valid,
  input  tile_lookup_t               pix,
  output logic [`REG_DATA_WIDTH-1:0] reg_rdata,
  output logic                       reg_rvalid,
  output logic                       res_valid,
  output tile_result_t               res
);

  tile_regs_t   regs;
  logic         dec_valid;
  tile_lookup_t dec_pix;
  tile_cfg_t    cfg;

  tile_reg_bank u_reg_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .regs       (regs)
  );

  // Stage 1 registers the lookup with its layer's fields
  tile_reg_decoder u_reg_decoder (
    .clk       (clk),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .pix       (pix),
    .regs      (regs),
    .dec_valid (dec_valid),
    .dec_pix   (dec_pix),
    .cfg       (cfg)
  );

  // Stage 2 registers the address result
  tile_addr_gen u_addr_gen (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec_pix   (dec_pix),
    .cfg       (cfg),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

//--- logic/tile_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the tile layer setup path
// The CTRL0 flag order must follow the bit positions in tile_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

package tile_pkg;

  typedef logic [`REG_DATA_WIDTH-1:0]                   tile_word_t;
  typedef logic [$clog2(`NUM_TILE_LAYERS)-1:0]          tile_layer_t;
  typedef logic [$clog2(`NUM_TILE_REGISTERS)-1:0]       tile_reg_idx_t;
  typedef logic [`SCREEN_COORD_WIDTH-1:0]               tile_coord_t;
  typedef logic [`TILE_PX_WIDTH-1:0]                    tile_px_t;

  typedef struct packed {
    tile_layer_t   layer;
    tile_reg_idx_t index;
  } tile_reg_addr_t;

  // Listed from the top bit down so each flag lands on its CTRL0 position
  typedef struct packed {
    logic [`REG_DATA_WIDTH-`TILE_ENABLE_FLIP-2:0] rsvd;
    logic flip;
    logic wrap_y;
    logic wrap_x;
    logic color;
    logic alpha;
    logic transp;
    logic scroll;
    logic nop;
    logic en_8bit;
    logic enabled;
  } tile_ctrl0_flags_t;

  typedef union packed {
    tile_word_t        raw;
    tile_ctrl0_flags_t flags;
  } tile_ctrl0_u;

  // Tile side is 8 pixels shifted left by the enum value
  typedef enum logic [1:0] {
    TILE_SIZE_8  = 2'd0,
    TILE_SIZE_16 = 2'd1,
    TILE_SIZE_32 = 2'd2,
    TILE_SIZE_64 = 2'd3
  } tile_size_e;

  typedef struct packed {
    tile_ctrl0_u ctrl0;
    tile_word_t  ctrl1;
    tile_size_e  hsize;
    tile_size_e  vsize;
    tile_word_t  data_offset;
    tile_word_t  nop_value;
    tile_word_t  color_key;
    tile_word_t  offset_x;
    tile_word_t  offset_y;
  } tile_cfg_t;

  typedef struct packed {
    tile_layer_t layer;
    tile_coord_t x;
    tile_coord_t y;
  } tile_lookup_t;

  typedef struct packed {
    tile_layer_t layer;
    logic        hit;
    tile_word_t  map_addr;
    tile_px_t    px_x;
    tile_px_t    px_y;
    logic        en_8bit;
    logic        nop;
    logic        transp;
    logic        alpha;
    logic        color;
    tile_word_t  nop_value;
    tile_word_t  color_key;
  } tile_result_t;

  typedef logic [`NUM_TILE_LAYERS-1:0][`NUM_TILE_REGISTERS-1:0][`REG_DATA_WIDTH-1:0]
      tile_regs_t;

endpackage

//--- logic/tile_reg_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register storage for all tile layers
// Writes land on the strobe edge and reads return one cycle later
// Writes to index 7 are dropped and reads of it return zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

module tile_reg_bank
  import tile_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  input  tile_reg_addr_t             reg_addr,
  input  logic [`REG_DATA_WIDTH-1:0] reg_wdata,
  output logic [`REG_DATA_WIDTH-1:0] reg_rdata,
  output logic                       reg_rvalid,
  output tile_regs_t                 regs
);

  tile_regs_t store;
  logic       addr_reserved;

  // Everything above the last defined index is reserved
  assign addr_reserved = (reg_addr.index > tile_reg_idx_t'(`TILE_OFFSET_Y));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      store <= '0;
    end else if (reg_wr && !addr_reserved) begin
      store[reg_addr.layer][reg_addr.index] <= reg_wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  // Read data holds its value between reads
  always_ff @(posedge clk) begin
    if (reg_rd) begin
      if (addr_reserved) begin
        reg_rdata <= '0;
      end else begin
        reg_rdata <= store[reg_addr.layer][reg_addr.index];
      end
    end
  end

  // The decoder sees the words as they stand before this edge's write
  assign regs = store;

endmodule

//--- logic/tile_reg_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Selects the looked-up layer and splits its words into fields
// Output is registered so results trail pix_valid by one cycle
// No back-pressure and a new lookup may come every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

module tile_reg_decoder
  import tile_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         pix_valid,
  input  tile_lookup_t pix,
  input  tile_regs_t   regs,
  output logic         dec_valid,
  output tile_lookup_t dec_pix,
  output tile_cfg_t    cfg
);

  logic [`NUM_TILE_REGISTERS-1:0][`REG_DATA_WIDTH-1:0] layer_regs;
  tile_cfg_t                                           cfg_next;

  assign layer_regs = regs[pix.layer];

  always_comb begin
    // The flag view of ctrl0 comes for free through the union
    cfg_next.ctrl0.raw   = layer_regs[`TILE_CTRL0];
    cfg_next.ctrl1       = layer_regs[`TILE_CTRL1];
    cfg_next.hsize       = tile_size_e'(layer_regs[`TILE_CTRL1][`TILE_HSIZE_1:`TILE_HSIZE_0]);
    cfg_next.vsize       = tile_size_e'(layer_regs[`TILE_CTRL1][`TILE_VSIZE_1:`TILE_VSIZE_0]);
    cfg_next.data_offset = layer_regs[`TILE_DATA_OFFSET];
    cfg_next.nop_value   = layer_regs[`TILE_NOP_VALUE];
    cfg_next.color_key   = layer_regs[`TILE_COLOR_KEY];
    cfg_next.offset_x    = layer_regs[`TILE_OFFSET_X];
    cfg_next.offset_y    = layer_regs[`TILE_OFFSET_Y];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pix_valid;
    end
  end

  // Payload only moves when a lookup is present
  always_ff @(posedge clk) begin
    if (pix_valid) begin
      dec_pix <= pix;
      cfg     <= cfg_next;
    end
  end

endmodule

//--- sim/tile_layer_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe timing checks, bound into every tile_layer_top
// Timing checks pause while arst_n is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tile_layer_sva (
  input logic clk,
  input logic arst_n,
  input logic reg_rd,
  input logic reg_rvalid,
  input logic pix_valid,
  input logic res_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Read data comes back exactly one cycle after the strobe
  a_rvalid_after_rd: assert property (@(posedge clk) disable iff (!arst_n)
    reg_rd |=> reg_rvalid)
    else begin
      $error("reg_rvalid did not follow reg_rd after one cycle");
      fail_count++;
    end

  a_rvalid_needs_rd: assert property (@(posedge clk) disable iff (!arst_n)
    reg_rvalid |-> $past(reg_rd))
    else begin
      $error("reg_rvalid pulsed without a reg_rd one cycle earlier");
      fail_count++;
    end

  // Two pipeline stages between a lookup and its result
  a_res_after_pix: assert property (@(posedge clk) disable iff (!arst_n)
    pix_valid |-> ##2 res_valid)
    else begin
      $error("res_valid did not follow pix_valid after two cycles");
      fail_count++;
    end

  a_res_needs_pix: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid |-> $past(pix_valid, 2))
    else begin
      $error("res_valid pulsed without a pix_valid two cycles earlier");
      fail_count++;
    end

  a_no_res_in_reset: assert property (@(posedge clk) !arst_n |-> !res_valid)
    else begin
      $error("res_valid high while arst_n is low");
      fail_count++;
    end

endmodule

bind tile_layer_top tile_layer_sva u_sva (.*);

//--- sim/tile_layer_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for tile_layer_top, run from the project root
// Commands come from sim/tile_layer_testdata.txt
// Pass-through fields are predicted from the writes seen so far
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_defs.svh"

module tile_layer_tb
  import tile_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    tile_layer_t layer;
    logic        hit;
    tile_word_t  map_addr;
    tile_px_t    px_x;
    tile_px_t    px_y;
    logic [4:0]  flags;
    tile_word_t  nop_value;
    tile_word_t  color_key;
    logic [31:0] due;
  } expect_t;

  logic           clk;
  logic           arst_n;
  logic           reg_wr;
  logic           reg_rd;
  tile_reg_addr_t reg_addr;
  tile_word_t     reg_wdata;
  logic           pix_valid;
  tile_lookup_t   pix;
  tile_word_t     reg_rdata;
  logic           reg_rvalid;
  logic           res_valid;
  tile_result_t   res;

  expect_t        pending[$];
  tile_word_t     shadow [`NUM_TILE_LAYERS][`NUM_TILE_REGISTERS];
  int             errors;
  logic [31:0]    cycle;

  tile_layer_top DUT (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 32'd1;
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got %0h, expected %0h", name, got, want);
      errors++;
    end
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input int unsigned layer, input int unsigned idx,
                           input logic [31:0] data);
    reg_wr          = 1'b1;
    reg_addr.layer  = tile_layer_t'(layer);
    reg_addr.index  = tile_reg_idx_t'(idx);
    reg_wdata       = tile_word_t'(data);
    if (idx <= `TILE_OFFSET_Y) begin
      shadow[layer][idx] = tile_word_t'(data);
    end
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input int unsigned layer, input int unsigned idx,
                          input logic [31:0] want);
    int waited;
    reg_rd         = 1'b1;
    reg_addr.layer = tile_layer_t'(layer);
    reg_addr.index = tile_reg_idx_t'(idx);
    @(posedge clk);
    #1;
    reg_rd = 1'b0;
    waited = 0;
    while (!reg_rvalid && waited < 50) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!reg_rvalid) begin
      $display("Read of layer %0d index %0d never returned reg_rvalid", layer, idx);
      errors++;
    end else begin
      check_field("reg_rdata", reg_rdata, want);
    end
  endtask

  task automatic lookup_pixel(input int unsigned layer, input logic [31:0] x,
                              input logic [31:0] y, input logic [31:0] f [0:6]);
    expect_t e;
    tile_word_t c0;
    c0         = shadow[layer][`TILE_CTRL0];
    pix_valid  = 1'b1;
    pix.layer  = tile_layer_t'(layer);
    pix.x      = tile_coord_t'(x);
    pix.y      = tile_coord_t'(y);
    e.layer    = tile_layer_t'(layer);
    e.hit      = f[3][0];
    e.map_addr = tile_word_t'(f[4]);
    e.px_x     = tile_px_t'(f[5]);
    e.px_y     = tile_px_t'(f[6]);
    e.flags    = {c0[`TILE_ENABLE_8_BIT], c0[`TILE_ENABLE_NOP], c0[`TILE_ENABLE_TRANSP],
                  c0[`TILE_ENABLE_ALPHA], c0[`TILE_ENABLE_COLOR]};
    e.nop_value = shadow[layer][`TILE_NOP_VALUE];
    e.color_key = shadow[layer][`TILE_COLOR_KEY];
    e.due       = cycle + 32'd2;
    pending.push_back(e);
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
  endtask

  // Results are sampled on the falling edge, well away from the update
  always @(negedge clk) begin : check_results
    expect_t e;
    if (res_valid) begin
      if (pending.size() == 0) begin
        $display("A result arrived for layer %0d with no lookup outstanding", res.layer);
        errors++;
      end else begin
        e = pending.pop_front();
        check_field("latency cycle", cycle, e.due);
        check_field("res.layer", res.layer, e.layer);
        check_field("res.hit", res.hit, e.hit);
        check_field("res.map_addr", res.map_addr, e.map_addr);
        check_field("res.px_x", res.px_x, e.px_x);
        check_field("res.px_y", res.px_y, e.px_y);
        check_field("res.flags", {res.en_8bit, res.nop, res.transp, res.alpha, res.color},
                    e.flags);
        check_field("res.nop_value", res.nop_value, e.nop_value);
        check_field("res.color_key", res.color_key, e.color_key);
      end
    end
  end

  initial begin
    int          fd;
    int          waited;
    string       line;
    byte         cmd;
    logic [31:0] f [0:6];
    bit          burst;
    arst_n    = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    pix_valid = 1'b0;
    pix       = '0;
    errors    = 0;
    cycle     = '0;
    burst     = 1'b0;
    foreach (shadow[l, r]) shadow[l][r] = '0;
    void'($urandom(9));
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    fd = $fopen("sim/tile_layer_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file sim/tile_layer_testdata.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        cmd = 8'h0;
        void'($sscanf(line, "%c %h %h %h %h %h %h %h", cmd, f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6]));
        case (cmd)
          "W": begin
            burst = 1'b0;
            idle_gap();
            write_reg(f[0], f[1], f[2]);
          end
          "R": begin
            burst = 1'b0;
            idle_gap();
            read_reg(f[0], f[1], f[2]);
          end
          "P": begin
            if (!burst) idle_gap();
            lookup_pixel(f[0], f[1], f[2], f);
          end
          "B": burst = 1'b1;
          "#", "\n", "\r", 8'h0: ;
          default: begin
            $display("Unknown command in the data file: %s", line);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    // Let the last lookups come out of the pipeline
    waited = 0;
    while (pending.size() != 0 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      $display("res_valid never came for %0d outstanding lookups", pending.size());
      errors++;
    end

    // Strobe timing failures seen by the bound checker
    errors += DUT.u_sva.fail_count;

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim/tile_layer_testdata.txt
# W layer index data | R layer index expected | P layer x y hit map_addr px_x px_y
# B starts a back-to-back burst of the P lines after it; all fields are hex
R 0 0 0000
R 3 6 0000
P 0 010 020 0 0000 00 00
P 1 010 020 0 0000 00 00
P 2 3ff 3ff 0 0000 00 00
P 3 000 000 0 0000 00 00
W 0 0 0001
W 0 2 0100
W 1 0 0051
W 1 1 0021
W 1 2 0200
W 2 0 0001
W 2 1 0033
W 2 2 1000
W 3 0 027f
W 3 1 0012
W 3 2 2000
W 3 3 1234
W 3 4 beef
W 3 5 0300
W 3 6 0010
W 0 7 ffff
R 0 7 0000
R 0 2 0100
R 1 0 0051
R 2 1 0033
R 3 4 beef
R 3 5 0300
P 0 025 013 1 0144 05 03
P 1 123 0c7 1 02d2 03 07
P 2 2a5 1f0 1 10ea 25 30
P 3 005 003 1 2038 1a 03
P 3 100 000 0 0000 00 00
W 3 0 03ff
P 3 100 000 1 2020 1f 00
W 3 6 fff0
P 3 005 003 1 23f8 1a 03
W 3 0 02ff
P 3 005 003 0 0000 00 00
B
P 0 025 013 1 0144 05 03
P 1 123 0c7 1 02d2 03 07
P 2 2a5 1f0 1 10ea 25 30
P 3 005 003 0 0000 00 00
P 0 0f8 0f8 1 04ff 00 00
